// ==== rv_core_top.f ====
source/rv_core_pkg.sv
source/pc_unit.sv
source/instr_decode.sv
source/alu_branch.sv
source/muldiv_unit.sv
source/result_writeback.sv
source/rv_core_top.sv
testbench/tb_clock_gen.sv
testbench/rv_core_tb.sv

// ==== source/alu_branch.sv ====
`timescale 1ns/1ps

module alu_branch (
    input  logic [31:0]          fetch_pc,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    input  logic [31:0]          imm,
    input  rv_core_pkg::alu_op_e alu_op,
    input  logic                 use_imm,
    input  logic                 use_pc,
    input  logic                 is_jal,
    input  logic                 is_jalr,
    input  logic                 is_branch,
    input  logic [2:0]           branch_funct,
    output logic [31:0]          alu_result,
    output logic [31:0]          target,
    output logic                 redirect
);

    import rv_core_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] jalr_sum;
    logic        taken;

    assign op_a = use_pc  ? fetch_pc : rs1_data;  // auipc
    assign op_b = use_imm ? imm      : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_PASS_B: alu_out = op_b;  // lui
            default:    alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (branch_funct)
            F3_BEQ:  taken = (rs1_data == rs2_data);
            F3_BNE:  taken = (rs1_data != rs2_data);
            F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum   = rs1_data + imm;
    assign target     = is_jalr ? {jalr_sum[31:1], 1'b0} : fetch_pc + imm;
    assign redirect   = is_jal || is_jalr || (is_branch && taken);
    assign alu_result = (is_jal || is_jalr) ? fetch_pc + 32'd4 : alu_out;  // link value

endmodule

// ==== source/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic [31:0]          fetch_instr,
    output logic [4:0]           rs1_idx,
    output logic [4:0]           rs2_idx,
    output logic [4:0]           rd,
    output logic [31:0]          imm,
    output rv_core_pkg::alu_op_e alu_op,
    output rv_core_pkg::md_op_e  md_op,
    output logic                 use_imm,
    output logic                 use_pc,
    output logic                 is_jal,
    output logic                 is_jalr,
    output logic                 is_branch,
    output logic                 is_muldiv,
    output logic                 rd_write,
    output logic [2:0]           branch_funct
);

    import rv_core_pkg::*;

    instr_u      iw;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        sub_or_sra;  // funct7 bit 5

    assign iw = fetch_instr;

    assign rs1_idx      = iw.r.rs1;
    assign rs2_idx      = iw.r.rs2;
    assign rd           = iw.r.rd;
    assign branch_funct = iw.r.funct3;
    assign sub_or_sra   = iw.r.funct7[5];

    assign imm_i = {{20{iw.i.imm[11]}}, iw.i.imm};
    // B, U and J scatter their bits over the other fields
    assign imm_b = {{20{fetch_instr[31]}}, fetch_instr[7], fetch_instr[30:25],
                    fetch_instr[11:8], 1'b0};
    assign imm_u = {fetch_instr[31:12], 12'b0};
    assign imm_j = {{12{fetch_instr[31]}}, fetch_instr[19:12], fetch_instr[20],
                    fetch_instr[30:21], 1'b0};

    always_comb begin
        alu_op    = ALU_ADD;
        md_op     = MD_MUL;
        imm       = imm_i;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_branch = 1'b0;
        is_muldiv = 1'b0;
        rd_write  = 1'b0;
        case (iw.r.opcode)
            OPC_OP, OPC_OP_IMM: begin
                use_imm  = (iw.r.opcode == OPC_OP_IMM);
                rd_write = 1'b1;
                if (iw.r.opcode == OPC_OP && iw.r.funct7 == FUNCT7_MULDIV) begin
                    is_muldiv = 1'b1;
                    case (iw.r.funct3)
                        F3_MUL:  md_op = MD_MUL;
                        F3_DIVU: md_op = MD_DIVU;
                        F3_REMU: md_op = MD_REMU;
                        default: begin
                            is_muldiv = 1'b0;  // mulh/div/rem etc, not supported
                            rd_write  = 1'b0;
                        end
                    endcase
                end else begin
                    case (iw.r.funct3)
                        F3_ADD_SUB: alu_op = (!use_imm && sub_or_sra) ? ALU_SUB : ALU_ADD;
                        F3_SLL:     alu_op = ALU_SLL;
                        F3_SLT:     alu_op = ALU_SLT;
                        F3_XOR:     alu_op = ALU_XOR;
                        F3_SRL_SRA: alu_op = sub_or_sra ? ALU_SRA : ALU_SRL;
                        F3_OR:      alu_op = ALU_OR;
                        F3_AND:     alu_op = ALU_AND;
                        default:    rd_write = 1'b0;  // sltu / sltiu
                    endcase
                end
            end
            OPC_LUI: begin
                imm      = imm_u;
                alu_op   = ALU_PASS_B;
                use_imm  = 1'b1;
                rd_write = 1'b1;
            end
            OPC_AUIPC: begin
                imm      = imm_u;
                use_imm  = 1'b1;
                use_pc   = 1'b1;
                rd_write = 1'b1;
            end
            OPC_JAL: begin
                imm      = imm_j;
                is_jal   = 1'b1;
                rd_write = 1'b1;
            end
            OPC_JALR: begin
                is_jalr  = 1'b1;
                rd_write = 1'b1;
            end
            OPC_BRANCH: begin
                imm       = imm_b;
                is_branch = (iw.r.funct3 == F3_BEQ) || (iw.r.funct3 == F3_BNE) ||
                            (iw.r.funct3 == F3_BLT) || (iw.r.funct3 == F3_BGE);
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
    end

endmodule

// ==== source/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                md_start,
    input  rv_core_pkg::md_op_e md_op,
    input  logic [31:0]         rs1_data,
    input  logic [31:0]         rs2_data,
    output logic                md_busy,
    output logic                md_finish,
    output logic [31:0]         md_result
);

    import rv_core_pkg::*;

    md_op_e      op_q;
    logic [5:0]  step_cnt;
    // mul: a = multiplicand, b = multiplier, r = product
    // div: a = divisor, b = dividend shifting into quotient, r = partial remainder
    logic [31:0] acc_a;
    logic [31:0] acc_b;
    logic [31:0] acc_r;
    logic [32:0] trial;  // remainder shifted left minus divisor

    assign trial = {acc_r, acc_b[31]} - {1'b0, acc_a};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_busy   <= 1'b0;
            md_finish <= 1'b0;
            step_cnt  <= 6'd0;
            op_q      <= MD_MUL;
        end else begin
            md_finish <= 1'b0;
            if (md_start) begin
                md_busy  <= 1'b1;
                step_cnt <= 6'd0;
                op_q     <= md_op;
            end else if (md_busy) begin
                if (step_cnt == 6'd32) begin
                    md_busy   <= 1'b0;
                    md_finish <= 1'b1;  // one cycle after the last step
                end else begin
                    step_cnt <= step_cnt + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) begin
            acc_a <= (md_op == MD_MUL) ? rs1_data : rs2_data;
            acc_b <= (md_op == MD_MUL) ? rs2_data : rs1_data;
            acc_r <= 32'd0;
        end else if (md_busy && step_cnt != 6'd32) begin
            if (op_q == MD_MUL) begin
                if (acc_b[0]) begin
                    acc_r <= acc_r + acc_a;
                end
                acc_a <= acc_a << 1;
                acc_b <= acc_b >> 1;
            end else if (!trial[32]) begin
                acc_r <= trial[31:0];  // divisor fits, quotient bit 1
                acc_b <= {acc_b[30:0], 1'b1};
            end else begin
                acc_r <= {acc_r[30:0], acc_b[31]};
                acc_b <= {acc_b[30:0], 1'b0};
            end
        end
    end

    // zero divisor always fits, so quotient ends all ones and remainder is the dividend
    assign md_result = (op_q == MD_DIVU) ? acc_b : acc_r;

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        md_start |-> !md_busy
    ) else $error("md_start while muldiv busy");

endmodule

// ==== source/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_valid,
    input  logic        redirect,
    input  logic [31:0] target,
    input  logic        is_muldiv,
    input  logic        md_finish,
    output logic        fetch_req,
    output logic [31:0] fetch_pc
);

    logic        boot_done;  // first request after reset already sent
    logic        pc_step;
    logic [31:0] pc_next;

    // muldiv holds the pc until its finish pulse
    assign pc_step = (fetch_valid && !is_muldiv) || md_finish;

    // md_finish never coincides with fetch_valid, so redirect only counts on a fetch
    assign pc_next = (fetch_valid && redirect) ? target : fetch_pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc  <= RESET_PC;
            boot_done <= 1'b0;
            fetch_req <= 1'b0;
        end else begin
            boot_done <= 1'b1;
            fetch_req <= !boot_done || pc_step;  // issue one cycle after each pc update
            if (pc_step) begin
                fetch_pc <= pc_next;
            end
        end
    end

    // one outstanding fetch at a time
    a_single_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_req |=> (!fetch_req until fetch_valid)
    ) else $error("fetch_req issued twice without fetch_valid");

endmodule

// ==== source/result_writeback.sv ====
`timescale 1ns/1ps

module result_writeback (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    input  logic [4:0]  rd,
    input  logic        rd_write,
    input  logic        fetch_valid,
    input  logic        is_muldiv,
    input  logic        md_finish,
    input  logic [31:0] alu_result,
    input  logic [31:0] md_result,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic [31:0] regs [32];
    logic [4:0]  md_rd;  // destination held across the muldiv run
    logic        alu_wr;
    logic        do_wr;
    logic [4:0]  wr_idx;
    logic [31:0] wr_data;

    assign alu_wr  = fetch_valid && !is_muldiv && rd_write;
    assign do_wr   = alu_wr || md_finish;
    assign wr_idx  = md_finish ? md_rd : rd;
    assign wr_data = md_finish ? md_result : alu_result;

    // x0 reads as zero
    assign rs1_data = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (fetch_valid && is_muldiv) begin
            md_rd <= rd;
        end
        if (do_wr && wr_idx != 5'd0) begin
            regs[wr_idx] <= wr_data;
        end
        wb_rd   <= wr_idx;
        wb_data <= (wr_idx == 5'd0) ? 32'd0 : wr_data;  // x0 write still traced
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= do_wr;
        end
    end

endmodule

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // funct3 for alu ops, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // M extension subset
    localparam logic [2:0] F3_MUL  = 3'b000;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REMU = 3'b111;

    // branch compares
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MD_MUL, MD_DIVU, MD_REMU
    } md_op_e;

    // one fetched word, seen as R-type or as I-type fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        fetch_req,
    output logic [31:0] fetch_pc,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_instr,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    import rv_core_pkg::*;

    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_e     alu_op;
    md_op_e      md_op;
    logic        use_imm;
    logic        use_pc;
    logic        is_jal;
    logic        is_jalr;
    logic        is_branch;
    logic        is_muldiv;
    logic        rd_write;
    logic [2:0]  branch_funct;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_result;
    logic [31:0] target;
    logic        redirect;
    logic        md_start;
    logic        md_busy;
    logic        md_finish;
    logic [31:0] md_result;

    assign md_start = fetch_valid && is_muldiv;

    pc_unit #(.RESET_PC(RESET_PC)) u_pc (
        .clk(clk), .rst_n(rst_n), .fetch_valid(fetch_valid), .redirect(redirect),
        .target(target), .is_muldiv(is_muldiv), .md_finish(md_finish),
        .fetch_req(fetch_req), .fetch_pc(fetch_pc)
    );

    instr_decode u_decode (
        .fetch_instr(fetch_instr), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd(rd),
        .imm(imm), .alu_op(alu_op), .md_op(md_op), .use_imm(use_imm), .use_pc(use_pc),
        .is_jal(is_jal), .is_jalr(is_jalr), .is_branch(is_branch), .is_muldiv(is_muldiv),
        .rd_write(rd_write), .branch_funct(branch_funct)
    );

    alu_branch u_alu (
        .fetch_pc(fetch_pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_op(alu_op), .use_imm(use_imm), .use_pc(use_pc), .is_jal(is_jal),
        .is_jalr(is_jalr), .is_branch(is_branch), .branch_funct(branch_funct),
        .alu_result(alu_result), .target(target), .redirect(redirect)
    );

    muldiv_unit u_muldiv (
        .clk(clk), .rst_n(rst_n), .md_start(md_start), .md_op(md_op),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .md_busy(md_busy),
        .md_finish(md_finish), .md_result(md_result)
    );

    result_writeback u_wb (
        .clk(clk), .rst_n(rst_n), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd(rd),
        .rd_write(rd_write), .fetch_valid(fetch_valid), .is_muldiv(is_muldiv),
        .md_finish(md_finish), .alu_result(alu_result), .md_result(md_result),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wb_en(wb_en), .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

endmodule

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    import rv_core_pkg::*;

    localparam int MAX_INSTR = 420;  // upper bound over all tests

    logic        clk;
    logic        rst_n;
    logic        fetch_req;
    logic [31:0] fetch_pc;
    logic        fetch_valid;
    logic [31:0] fetch_instr;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [MAX_INSTR];
    int          prog_len;
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic        req_pending;
    logic [31:0] req_pc;
    logic        md_outstanding;
    integer      seed;
    int          errors;
    int          checks;
    int          tests;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    rv_core_top #(.RESET_PC(32'h0000_0100)) u_dut (
        .clk(clk), .rst_n(rst_n), .fetch_req(fetch_req), .fetch_pc(fetch_pc),
        .fetch_valid(fetch_valid), .fetch_instr(fetch_instr), .wb_en(wb_en),
        .wb_rd(wb_rd), .wb_data(wb_data)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // integer op by funct3 and whether the core implements it
    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic sub, logic arith,
                                            logic [31:0] a, logic [31:0] b, output logic ok);
        ok = 1'b1;
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return arith ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            3'd7: return a & b;
            default: begin
                ok = 1'b0;
                return 32'd0;
            end
        endcase
    endfunction

    // executes one instruction on the model state and returns the expected trace
    function automatic void ref_exec(input logic [31:0] ins, output logic wr,
                                     output logic [4:0] rd, output logic [31:0] data,
                                     output logic is_md);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic        taken;
        f7      = ins[31:25];
        f3      = ins[14:12];
        rd      = ins[11:7];
        a       = model_regs[ins[19:15]];
        b       = model_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        next_pc = model_pc + 32'd4;
        wr      = 1'b0;
        is_md   = 1'b0;
        val     = 32'd0;
        taken   = 1'b0;
        case (ins[6:0])
            OPC_OP: begin
                if (f7 == FUNCT7_MULDIV) begin
                    is_md = (f3 == 3'd0) || (f3 == 3'd5) || (f3 == 3'd7);
                    wr    = is_md;
                    if (f3 == 3'd0) val = a * b;
                    else if (f3 == 3'd5) val = (b == 0) ? 32'hffff_ffff : a / b;
                    else val = (b == 0) ? a : a % b;
                end else begin
                    val = alu_ref(f3, f7[5], f7[5], a, b, wr);
                end
            end
            OPC_OP_IMM: val = alu_ref(f3, 1'b0, ins[30], a, imm_i, wr);
            OPC_LUI: begin
                wr  = 1'b1;
                val = {ins[31:12], 12'd0};
            end
            OPC_AUIPC: begin
                wr  = 1'b1;
                val = model_pc + {ins[31:12], 12'd0};
            end
            OPC_JAL: begin
                wr      = 1'b1;
                val     = model_pc + 32'd4;
                next_pc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                wr      = 1'b1;
                val     = model_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;  // low bit dropped
            end
            OPC_BRANCH: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        data = (rd == 5'd0) ? 32'd0 : val;
        if (wr && rd != 5'd0) model_regs[rd] = val;
        model_pc = next_pc;
    endfunction

    // kinds 0 to 3 are the plain alu group, 4 to 7 add jumps, branches and muldiv
    function automatic logic [31:0] rand_instr(input int kinds);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          kind;
        rd   = $random(seed);
        rs1  = $random(seed);
        rs2  = $random(seed);
        imm  = $random(seed);
        kind = $unsigned($random(seed)) % kinds;
        f3   = $random(seed);
        if (f3 == 3'd3) f3 = 3'd0;  // sltu is not supported
        case (kind)
            0: return enc_r((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, imm[0], 5'd0} : 7'd0,
                            rs2, rs1, f3, rd);
            1: begin
                if (f3 == 3'd1) imm[11:5] = 7'd0;
                if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'd0};
                return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            2: return {imm, rs1, 3'd0, rd, OPC_LUI};
            3: return {imm, rs2, 3'd0, rd, OPC_AUIPC};
            4: return enc_j({{9{imm[11]}}, imm[10:0], 1'b0}, rd);
            5: return enc_i(imm, rs1, 3'd0, rd, OPC_JALR);
            6: return enc_b({imm, 1'b0}, rs2, rs1, {f3[2], 1'b0, f3[0]});
            default: return enc_r(FUNCT7_MULDIV, rs2, rs1, (f3[0]) ? 3'd5 : {f3[1], 2'b00} | 3'd0,
                                  rd) | {17'd0, f3[1] & f3[0], f3[1] & f3[0], 12'd0};
        endcase
    endfunction

    // memory side answering each request after 1 to 4 cycles
    task automatic run_program(input string name);
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        is_md;
        int          delay;
        int          err_before;
        err_before = errors;
        for (int i = 0; i < prog_len; i++) begin
            while (!req_pending) @(posedge clk);
            if (req_pc !== model_pc) begin
                $display("fetch address %h differs from model pc %h", req_pc, model_pc);
                errors++;
            end
            delay = 1 + $unsigned($random(seed)) % 4;
            repeat (delay - 1) @(posedge clk);
            fetch_valid <= 1'b1;
            fetch_instr <= prog[i];
            req_pending = 1'b0;  // answered
            ref_exec(prog[i], wr, rd, data, is_md);
            if (wr) begin
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(data);
            end
            md_outstanding = is_md;
            @(posedge clk);
            fetch_valid <= 1'b0;
            fetch_instr <= 32'd0;
        end
        while (exp_rd_q.size() != 0 || md_outstanding) @(posedge clk);
        tests++;
        $display("test %0d %s: %0d instructions, %0d errors", tests, name, prog_len,
                 errors - err_before);
    endtask

    // compare process and request monitor
    always @(posedge clk) begin
        if (rst_n && wb_en) begin
            md_outstanding = 1'b0;
            if (exp_rd_q.size() == 0) begin
                $display("write-back of x%0d came with no expected result", wb_rd);
                errors++;
            end else begin
                check("wb_rd", {27'd0, wb_rd}, {27'd0, exp_rd_q.pop_front()});
                check("wb_data", wb_data, exp_data_q.pop_front());
            end
        end
        if (rst_n && fetch_req) begin
            if (md_outstanding) begin
                $display("fetch request while multiply/divide was still running");
                errors++;
            end
            if (req_pending) begin
                $display("second fetch request before the first was answered");
                errors++;
            end
            req_pending = 1'b1;
            req_pc      = fetch_pc;
        end
    end

    initial begin
        #((MAX_INSTR * 40 * 40) + 4000);
        $display("timeout: core stopped making progress");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        fetch_valid    = 1'b0;
        fetch_instr    = 32'd0;
        seed           = 32'h4588b48e;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        req_pending    = 1'b0;
        md_outstanding = 1'b0;
        model_pc       = 32'h0000_0100;
        foreach (model_regs[r]) model_regs[r] = 32'd0;

        // load every register before the first read
        prog_len = 0;
        for (int r = 1; r < 32; r++) prog[prog_len++] = {32'($random(seed)) & 32'hffff_f000}
                                                       | {20'd0, 5'(r), OPC_LUI};
        for (int r = 1; r < 32; r++) prog[prog_len++] = enc_i($random(seed), 5'(r), 3'd0,
                                                              5'(r), OPC_OP_IMM);
        for (int k = 0; k < 40; k++) prog[prog_len++] = rand_instr(4);
        run_program("alu ops");

        prog_len = 0;
        prog[prog_len++] = enc_i(12'd7, 5'd5, 3'd0, 5'd0, OPC_OP_IMM);
        prog[prog_len++] = enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0);
        prog[prog_len++] = {20'habcde, 5'd0, OPC_LUI};
        prog[prog_len++] = enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd3);
        prog[prog_len++] = enc_i(12'd5, 5'd0, 3'd0, 5'd4, OPC_OP_IMM);
        prog[prog_len++] = enc_r(7'h20, 5'd7, 5'd0, 3'd0, 5'd6);
        run_program("x0 writes");

        prog_len = 0;
        prog[prog_len++] = enc_j(21'd16, 5'd1);
        prog[prog_len++] = enc_i(12'd5, 5'd1, 3'd0, 5'd2, OPC_JALR);  // odd target
        prog[prog_len++] = enc_i(12'd5, 5'd0, 3'd0, 5'd8, OPC_OP_IMM);
        prog[prog_len++] = enc_i(12'd5, 5'd0, 3'd0, 5'd9, OPC_OP_IMM);
        prog[prog_len++] = enc_i(-12'sd3, 5'd0, 3'd0, 5'd10, OPC_OP_IMM);
        prog[prog_len++] = enc_b(13'd24, 5'd9, 5'd8, F3_BEQ);
        prog[prog_len++] = enc_b(13'd24, 5'd10, 5'd8, F3_BEQ);
        prog[prog_len++] = enc_b(-13'sd8, 5'd10, 5'd8, F3_BNE);
        prog[prog_len++] = enc_b(13'd40, 5'd9, 5'd8, F3_BNE);
        prog[prog_len++] = enc_b(13'd12, 5'd8, 5'd10, F3_BLT);
        prog[prog_len++] = enc_b(13'd12, 5'd10, 5'd8, F3_BLT);
        prog[prog_len++] = enc_b(-13'sd32, 5'd10, 5'd8, F3_BGE);
        prog[prog_len++] = enc_b(13'd12, 5'd8, 5'd10, F3_BGE);
        prog[prog_len++] = enc_j(-21'sd64, 5'd0);
        run_program("jumps and branches");

        prog_len = 0;
        for (int k = 0; k < 6; k++) begin
            prog[prog_len++] = {20'($random(seed)), 5'd20, OPC_LUI};
            prog[prog_len++] = enc_i($random(seed), 5'd0, 3'd0, 5'd21, OPC_OP_IMM);
            prog[prog_len++] = enc_r(FUNCT7_MULDIV, 5'd21, 5'd20, F3_MUL, 5'd23);
            prog[prog_len++] = enc_r(FUNCT7_MULDIV, 5'd21, 5'd20, F3_DIVU, 5'd24);
            prog[prog_len++] = enc_r(FUNCT7_MULDIV, 5'd21, 5'd20, F3_REMU, 5'd25);
        end
        prog[prog_len++] = enc_i(12'd0, 5'd0, 3'd0, 5'd22, OPC_OP_IMM);
        prog[prog_len++] = enc_r(FUNCT7_MULDIV, 5'd0, 5'd20, F3_DIVU, 5'd26);
        prog[prog_len++] = enc_r(FUNCT7_MULDIV, 5'd22, 5'd20, F3_REMU, 5'd27);
        run_program("multiply and divide");

        prog_len = 0;
        for (int k = 0; k < 250; k++) prog[prog_len++] = rand_instr(8);
        run_program("random mix");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
